// File: src.f
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
write_channel/write_channel.sv
read_channel/read_channel.sv
logic/back_end_arbiter.sv
logic/cache_back_end.sv
sim/be_mem_model.sv
sim/tb_cache_back_end.sv

// File: sim/tb_cache_back_end.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module tb_cache_back_end;

   typedef struct packed {
      logic [3:0]                 test;
      mem_pkg::mem_op_t           op;
      logic [`CACHE_ADDR_W-1:0]   addr;     // byte address
      logic [`CACHE_DATA_W-1:0]   word;
      logic [`CACHE_NBYTES-1:0]   strb;
      logic                       together; // launch with the next entry
   } entry_t;

   localparam int N_ENTRIES   = 11;
   localparam int LIMIT       = N_ENTRIES * (`CACHE_LINE_WORDS * 4 + 8);
   localparam int DRIVE_DELAY = 2;

   logic                                  clk;
   logic                                  reset;
   logic                                  wr_valid;
   logic [`CACHE_ADDR_W-1:`CACHE_NBYTES_W] wr_addr;
   logic [`CACHE_NBYTES-1:0]               wr_wstrb;
   logic [`CACHE_DATA_W-1:0]               wr_wdata;
   logic                                  wr_ready;
   logic                                  rd_valid;
   logic [`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W+`CACHE_LINE_WORDS_W] rd_addr;
   logic                                  rd_ready;
   logic                                  rd_data_valid;
   mem_pkg::be_data_t                     rd_data;
   cache_pkg::word_idx_t                  rd_word;
   logic                                  mem_valid;
   mem_pkg::be_addr_t                     mem_addr;
   mem_pkg::be_data_t                     mem_wdata;
   mem_pkg::be_strb_t                     mem_wstrb;
   mem_pkg::be_data_t                     mem_rdata;
   logic                                  mem_ready;

   entry_t               tbl [N_ENTRIES];
   string                test_names [7];
   mem_pkg::be_data_t    exp_mem [int];
   mem_pkg::mem_op_t     op_q [$];
   cache_pkg::word_idx_t next_idx;
   int                   read_base;
   int                   beats_left = 0;
   int                   errors = 0;
   int                   checks = 0;
   int                   op_errors = 0;
   int                   tests_failed = 0;
   int                   cycles = 0;

   cache_back_end DUT (.*);

   be_mem_model #(.SEED(16332)) u_mem (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
   end

   task automatic check_word(input string what, input mem_pkg::be_data_t got,
                             input mem_pkg::be_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_index(input string what, input cache_pkg::word_idx_t got,
                              input cache_pkg::word_idx_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_op(input string what, input mem_pkg::mem_op_t got,
                           input mem_pkg::mem_op_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         op_errors++;
         $display("Mismatch at %0t ns: %s got %s expected %s", $time, what,
                  got.name(), exp.name());
      end
   endtask

   task automatic check_ready(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // untouched words hold their byte address repeated
   function automatic mem_pkg::be_data_t exp_word(input int idx);
      logic [`CACHE_ADDR_W-1:0] a;
      a = idx << `CACHE_BE_NBYTES_W;
      if (exp_mem.exists(idx))
         return exp_mem[idx];
      return {(`CACHE_BE_DATA_W/`CACHE_ADDR_W){a}};
   endfunction

   task automatic expect_write(input logic [`CACHE_ADDR_W-1:0] addr,
                               input logic [`CACHE_DATA_W-1:0] word,
                               input logic [`CACHE_NBYTES-1:0] strb);
      int                idx;
      int                lane;
      mem_pkg::be_data_t w;
      idx  = addr[`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W];
      lane = addr[`CACHE_BE_NBYTES_W-1:`CACHE_NBYTES_W];
      w    = exp_word(idx);
      for (int b = 0; b < `CACHE_NBYTES; b++)
         if (strb[b])
            w[8*(lane*`CACHE_NBYTES+b) +: 8] = word[8*b +: 8];
      exp_mem[idx] = w;
   endtask

   task automatic launch(input entry_t e);
      if (e.op == mem_pkg::op_write) begin
         wr_valid = 1'b1;
         wr_addr  = e.addr[`CACHE_ADDR_W-1:`CACHE_NBYTES_W];
         wr_wstrb = e.strb;
         wr_wdata = e.word;
         expect_write(e.addr, e.word, e.strb);
         op_q.push_back(mem_pkg::op_write);
      end else begin
         rd_valid   = 1'b1;
         rd_addr    = e.addr[`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W+`CACHE_LINE_WORDS_W];
         read_base  = e.addr[`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W];
         next_idx   = '0;
         beats_left = `CACHE_LINE_WORDS;
         repeat (`CACHE_LINE_WORDS) op_q.push_back(mem_pkg::op_read);
      end
   endtask

   // keep each request up until its channel takes it
   task automatic hold_until_accepted();
      logic wr_taken;
      logic rd_taken;
      wr_taken = !wr_valid;
      rd_taken = !rd_valid;
      while (!(wr_taken && rd_taken)) begin
         @(negedge clk);
         if (wr_valid && wr_ready)
            wr_taken = 1'b1;
         if (rd_valid && rd_ready)
            rd_taken = 1'b1;
         @(posedge clk);
         #DRIVE_DELAY;
         if (wr_taken)
            wr_valid = 1'b0;
         if (rd_taken)
            rd_valid = 1'b0;
      end
   endtask

   // both channels idle and every refill word seen
   task automatic wait_done();
      @(negedge clk);
      while (!(wr_ready && rd_ready && beats_left == 0)) begin
         if (rd_data_valid) begin
            if (beats_left == 0) begin
               errors++;
               $display("error at %0t ns: refill word returned with no read pending", $time);
            end else begin
               check_index("refill word index", rd_word, next_idx);
               check_word("refill data", rd_data, exp_word(read_base + next_idx));
               next_idx++;
               beats_left--;
            end
         end
         @(negedge clk);
      end
   endtask

   task automatic report_test(input int num, input int nerr);
      if (nerr == 0) begin
         $display("test %0d %s: ok", num, test_names[num]);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, test_names[num], nerr);
      end
   endtask

   // every memory beat against the order of table launches
   always @(negedge clk) begin
      if (!reset && mem_valid && mem_ready) begin
         if (op_q.size() == 0) begin
            errors++;
            op_errors++;
            $display("error at %0t ns: memory transfer with no table entry pending", $time);
         end else begin
            check_op("memory operation",
                     (mem_wstrb != '0) ? mem_pkg::op_write : mem_pkg::op_read,
                     op_q.pop_front());
         end
      end
   end

   initial begin
      int         i;
      int         first_err;
      logic [3:0] cur_test;
      reset    = 1'b1;
      wr_valid = 1'b0;
      wr_addr  = '0;
      wr_wstrb = '0;
      wr_wdata = '0;
      rd_valid = 1'b0;
      rd_addr  = '0;
      test_names = '{"", "reset state", "line refill", "partial write then refill",
                     "write and read together", "back-to-back writes", "memory operations"};
      tbl = '{
         '{4'd2, mem_pkg::op_read,  16'h0040, 32'h0000_0000, 4'b0000, 1'b0},
         '{4'd3, mem_pkg::op_write, 16'h0044, 32'ha5a5_1234, 4'b0110, 1'b0}, // upper lane
         '{4'd3, mem_pkg::op_read,  16'h0040, 32'h0000_0000, 4'b0000, 1'b0},
         '{4'd4, mem_pkg::op_write, 16'h0108, 32'hcafe_f00d, 4'b1111, 1'b1},
         '{4'd4, mem_pkg::op_read,  16'h0100, 32'h0000_0000, 4'b0000, 1'b0},
         '{4'd5, mem_pkg::op_write, 16'h0200, 32'h1111_2222, 4'b1111, 1'b0},
         '{4'd5, mem_pkg::op_write, 16'h020c, 32'h3333_4444, 4'b1001, 1'b0},
         '{4'd5, mem_pkg::op_write, 16'h0234, 32'h5555_6666, 4'b0011, 1'b0},
         '{4'd5, mem_pkg::op_write, 16'h0204, 32'h7777_8888, 4'b1100, 1'b0},
         '{4'd5, mem_pkg::op_read,  16'h0200, 32'h0000_0000, 4'b0000, 1'b0},
         '{4'd5, mem_pkg::op_read,  16'h0220, 32'h0000_0000, 4'b0000, 1'b0}
      };
      repeat (3) @(posedge clk);
      #DRIVE_DELAY reset = 1'b0;
      @(negedge clk);
      first_err = errors;
      check_ready("wr_ready after reset", wr_ready, 1'b1);
      check_ready("rd_ready after reset", rd_ready, 1'b1);
      check_ready("mem_valid after reset", mem_valid, 1'b0);
      check_ready("rd_data_valid after reset", rd_data_valid, 1'b0);
      report_test(1, errors - first_err);
      i = 0;
      while (i < N_ENTRIES) begin
         cur_test  = tbl[i].test;
         first_err = errors;
         while (i < N_ENTRIES && tbl[i].test == cur_test) begin
            @(posedge clk);
            #DRIVE_DELAY;
            launch(tbl[i]);
            if (tbl[i].together && i + 1 < N_ENTRIES) begin
               i++;
               launch(tbl[i]);
            end
            i++;
            hold_until_accepted();
            // a write followed by a write goes out while the first is in flight
            if (!(i < N_ENTRIES && tbl[i].test == cur_test &&
                  tbl[i].op == mem_pkg::op_write && tbl[i - 1].op == mem_pkg::op_write))
               wait_done();
         end
         report_test(cur_test, errors - first_err);
      end
      if (op_q.size() != 0) begin
         errors++;
         op_errors++;
         $display("error: %0d expected memory transfers never happened", op_q.size());
      end
      report_test(6, op_errors);
      $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
               tests_failed, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: sim/be_mem_model.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module be_mem_model #(
   parameter int SEED = 16332
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              mem_valid,
   input  mem_pkg::be_addr_t mem_addr,
   input  mem_pkg::be_data_t mem_wdata,
   input  mem_pkg::be_strb_t mem_wstrb,
   output mem_pkg::be_data_t mem_rdata,
   output logic              mem_ready
);

   localparam int DEPTH = 1 << (`CACHE_ADDR_W - `CACHE_BE_NBYTES_W);

   mem_pkg::be_data_t shadow [DEPTH];
   logic [31:0]       rng;
   logic [1:0]        wait_cnt;
   logic              pending;
   logic [`CACHE_ADDR_W-`CACHE_BE_NBYTES_W-1:0] idx;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   assign idx = mem_addr[`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W];

   initial begin
      logic [`CACHE_ADDR_W-1:0] a;
      for (int i = 0; i < DEPTH; i++) begin
         a = i << `CACHE_BE_NBYTES_W; // byte address of the word
         shadow[i] = {(`CACHE_BE_DATA_W/`CACHE_ADDR_W){a}};
      end
   end

   always @(posedge clk, posedge reset) begin
      if (reset) begin
         mem_ready <= 1'b0;
         mem_rdata <= '0;
         pending   <= 1'b0;
         wait_cnt  <= '0;
         rng       <= SEED;
      end else if (mem_ready) begin
         mem_ready <= 1'b0; // handshake on this edge
         pending   <= 1'b0;
         for (int b = 0; b < `CACHE_BE_NBYTES; b++)
            if (mem_wstrb[b])
               shadow[idx][8*b +: 8] = mem_wdata[8*b +: 8];
      end else if (mem_valid && !pending) begin
         pending  <= 1'b1;
         rng      <= lcg_next(rng);
         wait_cnt <= rng[17:16]; // 0 to 3 extra cycles
      end else if (pending) begin
         if (wait_cnt == 0) begin
            mem_ready <= 1'b1;
            mem_rdata <= shadow[idx];
         end else begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end
   end

endmodule

// File: logic/cache_back_end.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module cache_back_end (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  wr_valid,
   input  logic [`CACHE_ADDR_W-1:`CACHE_NBYTES_W] wr_addr,
   input  logic [`CACHE_NBYTES-1:0]               wr_wstrb,
   input  logic [`CACHE_DATA_W-1:0]               wr_wdata,
   output logic                                  wr_ready,
   input  logic                                  rd_valid,
   input  logic [`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W+`CACHE_LINE_WORDS_W] rd_addr,
   output logic                                  rd_ready,
   output logic                                  rd_data_valid,
   output logic [`CACHE_BE_DATA_W-1:0]            rd_data,
   output logic [`CACHE_LINE_WORDS_W-1:0]         rd_word,
   output logic                                  mem_valid,
   output logic [`CACHE_ADDR_W-1:0]               mem_addr,
   output logic [`CACHE_BE_DATA_W-1:0]            mem_wdata,
   output logic [`CACHE_BE_NBYTES-1:0]            mem_wstrb,
   input  logic [`CACHE_BE_DATA_W-1:0]            mem_rdata,
   input  logic                                  mem_ready
);

   // write channel to arbiter
   logic                         wch_valid;
   logic [`CACHE_ADDR_W-1:0]     wch_addr;
   logic [`CACHE_BE_DATA_W-1:0]  wch_wdata;
   logic [`CACHE_BE_NBYTES-1:0]  wch_wstrb;
   logic                         wch_ready;

   // read channel to arbiter
   logic                         rch_valid;
   logic [`CACHE_ADDR_W-1:0]     rch_addr;
   logic                         rfl_last;
   logic                         rch_ready;
   logic [`CACHE_BE_DATA_W-1:0]  rch_rdata;

   write_channel u_write_channel (
      .clk       (clk),
      .reset     (reset),
      .wr_valid  (wr_valid),
      .wr_addr   (wr_addr),
      .wr_wstrb  (wr_wstrb),
      .wr_wdata  (wr_wdata),
      .wr_ready  (wr_ready),
      .wch_valid (wch_valid),
      .wch_addr  (wch_addr),
      .wch_wdata (wch_wdata),
      .wch_wstrb (wch_wstrb),
      .wch_ready (wch_ready)
   );

   read_channel u_read_channel (
      .clk           (clk),
      .reset         (reset),
      .rd_valid      (rd_valid),
      .rd_addr       (rd_addr),
      .rd_ready      (rd_ready),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data),
      .rd_word       (rd_word),
      .rch_valid     (rch_valid),
      .rch_addr      (rch_addr),
      .rfl_last      (rfl_last),
      .rch_ready     (rch_ready),
      .rch_rdata     (rch_rdata)
   );

   back_end_arbiter u_back_end_arbiter (
      .clk       (clk),
      .reset     (reset),
      .wch_valid (wch_valid),
      .wch_addr  (wch_addr),
      .wch_wdata (wch_wdata),
      .wch_wstrb (wch_wstrb),
      .wch_ready (wch_ready),
      .rch_valid (rch_valid),
      .rch_addr  (rch_addr),
      .rfl_last  (rfl_last),
      .rch_ready (rch_ready),
      .rch_rdata (rch_rdata),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

// File: logic/back_end_arbiter.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module back_end_arbiter (
   input  logic               clk,
   input  logic               reset,
   input  logic               wch_valid,
   input  mem_pkg::be_addr_t  wch_addr,
   input  mem_pkg::be_data_t  wch_wdata,
   input  mem_pkg::be_strb_t  wch_wstrb,
   output logic               wch_ready,
   input  logic               rch_valid,
   input  mem_pkg::be_addr_t  rch_addr,
   input  logic               rfl_last,
   output logic               rch_ready,
   output mem_pkg::be_data_t  rch_rdata,
   output logic               mem_valid,
   output mem_pkg::be_addr_t  mem_addr,
   output mem_pkg::be_data_t  mem_wdata,
   output mem_pkg::be_strb_t  mem_wstrb,
   input  mem_pkg::be_data_t  mem_rdata,
   input  logic               mem_ready
);

   mem_pkg::owner_t  owner;
   mem_pkg::mem_op_t op;

   logic beat_done;

   assign beat_done = mem_valid && mem_ready;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         owner <= mem_pkg::own_none;
      end else begin
         case (owner)
            mem_pkg::own_none: begin
               if (wch_valid)
                  owner <= mem_pkg::own_write; // write first, refill sees it
               else if (rch_valid)
                  owner <= mem_pkg::own_read;
            end
            mem_pkg::own_write: begin
               if (beat_done)
                  owner <= mem_pkg::own_none;
            end
            mem_pkg::own_read: begin
               if (beat_done && rfl_last)
                  owner <= mem_pkg::own_none;
            end
            default: owner <= mem_pkg::own_none;
         endcase
      end
   end

   assign op = (owner == mem_pkg::own_write) ? mem_pkg::op_write : mem_pkg::op_read;

   always_comb begin
      case (owner)
         mem_pkg::own_write: mem_valid = wch_valid;
         mem_pkg::own_read:  mem_valid = rch_valid;
         default:            mem_valid = 1'b0;
      endcase
   end

   assign mem_addr  = (op == mem_pkg::op_write) ? wch_addr : rch_addr;
   assign mem_wdata = (op == mem_pkg::op_write) ? wch_wdata : '0;
   assign mem_wstrb = (op == mem_pkg::op_write) ? wch_wstrb : '0; // zero strobe reads

   assign wch_ready = (owner == mem_pkg::own_write) && mem_ready;
   assign rch_ready = (owner == mem_pkg::own_read) && mem_ready;
   assign rch_rdata = mem_rdata;

   a_owner_held: assert property (
      @(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> $stable(owner)
   );

endmodule

// File: read_channel/read_channel.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module read_channel (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  rd_valid,
   input  logic [`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W+`CACHE_LINE_WORDS_W] rd_addr,
   output logic                                  rd_ready,
   output logic                                  rd_data_valid,
   output logic [`CACHE_BE_DATA_W-1:0]            rd_data,
   output logic [`CACHE_LINE_WORDS_W-1:0]         rd_word,
   output logic                                  rch_valid,
   output logic [`CACHE_ADDR_W-1:0]               rch_addr,
   output logic                                  rfl_last,
   input  logic                                  rch_ready,
   input  logic [`CACHE_BE_DATA_W-1:0]            rch_rdata
);

   cache_pkg::ch_state_t  state;
   cache_pkg::line_addr_t line_q;
   cache_pkg::word_idx_t  word_cnt;

   logic beat_done;

   assign beat_done = rch_valid && rch_ready;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state         <= cache_pkg::ch_idle;
         word_cnt      <= '0;
         rd_data_valid <= 1'b0;
      end else begin
         rd_data_valid <= beat_done; // one strobe per returned word
         case (state)
            cache_pkg::ch_idle: begin
               if (rd_valid) begin
                  state    <= cache_pkg::ch_busy;
                  word_cnt <= '0;
               end
            end
            cache_pkg::ch_busy: begin
               if (rch_ready) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (rfl_last)
                     state <= cache_pkg::ch_idle;
               end
            end
            default: state <= cache_pkg::ch_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_valid && rd_ready)
         line_q <= rd_addr;
      if (beat_done) begin
         rd_data <= rch_rdata;
         rd_word <= word_cnt;
      end
   end

   assign rd_ready  = (state == cache_pkg::ch_idle);
   assign rch_valid = (state == cache_pkg::ch_busy);

   // ascending beats within the line
   assign rch_addr = {line_q, word_cnt, {`CACHE_BE_NBYTES_W{1'b0}}};

   assign rfl_last = rch_valid &&
                     (word_cnt == cache_pkg::word_idx_t'(`CACHE_LINE_WORDS-1));

   // no gap inside a burst, the arbiter holds its grant on this
   a_burst_valid: assert property (
      @(posedge clk) disable iff (reset)
      rch_valid && !(rch_ready && rfl_last) |=> rch_valid
   );

   // after the last beat the channel is free again
   a_burst_end: assert property (
      @(posedge clk) disable iff (reset)
      rch_ready && rfl_last |=> rd_ready && rd_data_valid
   );

endmodule

// File: write_channel/write_channel.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module write_channel (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  wr_valid,
   input  logic [`CACHE_ADDR_W-1:`CACHE_NBYTES_W] wr_addr,
   input  logic [`CACHE_NBYTES-1:0]               wr_wstrb,
   input  logic [`CACHE_DATA_W-1:0]               wr_wdata,
   output logic                                  wr_ready,
   output logic                                  wch_valid,
   output logic [`CACHE_ADDR_W-1:0]               wch_addr,
   output logic [`CACHE_BE_DATA_W-1:0]            wch_wdata,
   output logic [`CACHE_BE_NBYTES-1:0]            wch_wstrb,
   input  logic                                  wch_ready
);

   cache_pkg::ch_state_t state;

   logic [`CACHE_ADDR_W-1:`CACHE_NBYTES_W] addr_q;
   logic [`CACHE_NBYTES-1:0]               strb_q;
   logic [`CACHE_DATA_W-1:0]               data_q;
   cache_pkg::lane_t                       lane;
   logic [`CACHE_BE_NBYTES-1:0]            lane_mask;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state <= cache_pkg::ch_idle;
      end else begin
         case (state)
            cache_pkg::ch_idle: begin
               if (wr_valid)
                  state <= cache_pkg::ch_busy;
            end
            cache_pkg::ch_busy: begin
               if (wch_ready)
                  state <= cache_pkg::ch_idle; // one beat per write
            end
            default: state <= cache_pkg::ch_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_valid && wr_ready) begin
         addr_q <= wr_addr;
         strb_q <= wr_wstrb;
         data_q <= wr_wdata;
      end
   end

   assign wr_ready  = (state == cache_pkg::ch_idle);
   assign wch_valid = (state == cache_pkg::ch_busy);

   assign lane      = addr_q[`CACHE_BE_NBYTES_W-1:`CACHE_NBYTES_W];
   assign wch_addr  = {addr_q[`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W], {`CACHE_BE_NBYTES_W{1'b0}}};
   assign wch_wdata = {(`CACHE_BE_DATA_W/`CACHE_DATA_W){data_q}}; // same word in every lane

   // bytes that belong to the addressed lane
   assign lane_mask = {{(`CACHE_BE_NBYTES-`CACHE_NBYTES){1'b0}}, {`CACHE_NBYTES{1'b1}}}
                      << (lane * `CACHE_NBYTES);

   always_comb begin
      wch_wstrb = '0;
      if (wch_valid)
         wch_wstrb = {{(`CACHE_BE_NBYTES-`CACHE_NBYTES){1'b0}}, strb_q}
                     << (lane * `CACHE_NBYTES);
   end

   a_strb_in_lane: assert property (
      @(posedge clk) disable iff (reset)
      wch_valid |-> (wch_wstrb & ~lane_mask) == '0
   );

   // a waiting write must not move under the arbiter
   a_write_held: assert property (
      @(posedge clk) disable iff (reset)
      wch_valid && !wch_ready |=> wch_valid && $stable(wch_wstrb) && $stable(wch_addr)
   );

endmodule

// File: common/mem_pkg.sv
`include "cache_cfg.svh"

package mem_pkg;

   // a zero strobe on the port is a read
   typedef enum logic [0:0] {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_t;

   typedef enum logic [1:0] {
      own_none  = 2'd0,
      own_write = 2'd1,
      own_read  = 2'd2
   } owner_t;

   // native memory port fields
   typedef logic [`CACHE_ADDR_W-1:0]    be_addr_t;
   typedef logic [`CACHE_BE_DATA_W-1:0] be_data_t;
   typedef logic [`CACHE_BE_NBYTES-1:0] be_strb_t;

endpackage

// File: common/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

   // shared by both channels
   typedef enum logic [0:0] {
      ch_idle = 1'b0,
      ch_busy = 1'b1
   } ch_state_t;

   // front word position inside a memory word
   typedef logic [`CACHE_BE_NBYTES_W-`CACHE_NBYTES_W-1:0] lane_t;

   // line address, byte address without word and byte offsets
   typedef logic [`CACHE_ADDR_W-1:`CACHE_BE_NBYTES_W+`CACHE_LINE_WORDS_W] line_addr_t;

   // memory word index in a line
   typedef logic [`CACHE_LINE_WORDS_W-1:0] word_idx_t;

endpackage

// File: common/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// front-end byte address and word
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32
`define CACHE_NBYTES 4
`define CACHE_NBYTES_W 2

// memory word
`define CACHE_BE_DATA_W 64
`define CACHE_BE_NBYTES 8
`define CACHE_BE_NBYTES_W 3

// line geometry in memory words
`define CACHE_LINE_WORDS 4
`define CACHE_LINE_WORDS_W 2

`endif
